// ==== include/rv_exec_defs.svh ====
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// Datapath widths
`define XLEN        32
`define INSTR_W     32
`define REG_ADDR_W  5
`define REG_COUNT   32
`define ALU_OP_W    4

// Major opcodes, instr[6:0]
`define OPC_LUI     7'b011_0111
`define OPC_OP_IMM  7'b001_0011
`define OPC_OP      7'b011_0011
`define OPC_BUBBLE  7'b000_0000   // All-zero word, inserted as a no-op

// funct3, instr[14:12]
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// ALU operation codes
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9

`endif

// ==== hw/rv_exec_pkg.sv ====
`include "rv_exec_defs.svh"

package rv_exec_pkg;

    // One register or ALU data word
    typedef logic [`XLEN-1:0] word_t;

    // Register file index, x0 to x31
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Operation select into the ALU
    typedef logic [`ALU_OP_W-1:0] alu_op_t;

    // Raw instruction word as fetched
    typedef logic [`INSTR_W-1:0] instr_t;

endpackage

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_alu (
    input  rv_exec_pkg::word_t   a,
    input  rv_exec_pkg::word_t   b,
    input  rv_exec_pkg::alu_op_t op,
    output rv_exec_pkg::word_t   result
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;     // Shift amount, upper bits of b ignored
    logic       lt_s;
    logic       lt_u;
    word_t      sra_val;

    assign shamt   = b[4:0];
    assign lt_s    = $signed(a) < $signed(b);
    assign lt_u    = a < b;
    assign sra_val = word_t'($signed(a) >>> shamt);  // Sign bit fills from the top

    always_comb begin
        case (op)
            `ALU_ADD:  result = a + b;
            `ALU_SUB:  result = a - b;
            `ALU_SLL:  result = a << shamt;
            `ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_s};
            `ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_u};
            `ALU_XOR:  result = a ^ b;
            `ALU_SRL:  result = a >> shamt;
            `ALU_SRA:  result = sra_val;
            `ALU_OR:   result = a | b;
            `ALU_AND:  result = a & b;
            default:   result = '0;   // Unused codes
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_exec_pkg::reg_addr_t rs1_addr,
    input  rv_exec_pkg::reg_addr_t rs2_addr,
    input  logic                   wr_en,
    input  rv_exec_pkg::reg_addr_t wr_addr,
    input  rv_exec_pkg::word_t     wr_data,
    output rv_exec_pkg::word_t     rs1_data,
    output rv_exec_pkg::word_t     rs2_data
);
    import rv_exec_pkg::*;

    word_t regs [1:`REG_COUNT-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads, x0 hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/inflight_forward.sv ====
`timescale 1ns/1ps

module inflight_forward (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_exec_pkg::reg_addr_t ex_rd,
    input  logic                   ex_wr,
    input  rv_exec_pkg::word_t     ex_result,  // Combinational ALU output
    input  rv_exec_pkg::reg_addr_t rs1_addr,
    input  rv_exec_pkg::reg_addr_t rs2_addr,
    input  rv_exec_pkg::word_t     rs1_data,   // Register file reads
    input  rv_exec_pkg::word_t     rs2_data,
    output rv_exec_pkg::word_t     rs1_value,
    output rv_exec_pkg::word_t     rs2_value,
    output logic                   wb_valid,
    output rv_exec_pkg::reg_addr_t wb_rd,
    output rv_exec_pkg::word_t     wb_data
);
    import rv_exec_pkg::*;

    // Memory stage, a pure delay here
    logic      mem_wr;
    reg_addr_t mem_rd;
    word_t     mem_data;

    // Newest producer wins: execute, then memory, then write-back
    function automatic word_t fwd_select(reg_addr_t src, word_t rf_value);
        word_t value;
        if (ex_wr && (ex_rd == src)) begin
            value = ex_result;
        end else if (mem_wr && (mem_rd == src)) begin
            value = mem_data;
        end else if (wb_valid && (wb_rd == src)) begin
            value = wb_data;        // Not yet in the register file
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    // Stage valid flags
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr   <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            mem_wr   <= ex_wr;
            wb_valid <= mem_wr;
        end
    end

    // Stage payload
    always_ff @(posedge clk) begin
        mem_rd   <= ex_rd;
        mem_data <= ex_result;
        wb_rd    <= mem_rd;
        wb_data  <= mem_data;
    end

    assign rs1_value = fwd_select(rs1_addr, rs1_data);
    assign rs2_value = fwd_select(rs2_addr, rs2_data);

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  rv_exec_pkg::instr_t    instr,
    input  rv_exec_pkg::word_t     rs1_value,  // Forwarded source operands
    input  rv_exec_pkg::word_t     rs2_value,
    output rv_exec_pkg::reg_addr_t rs1_addr,
    output rv_exec_pkg::reg_addr_t rs2_addr,
    output rv_exec_pkg::word_t     ex_a,
    output rv_exec_pkg::word_t     ex_b,
    output rv_exec_pkg::alu_op_t   ex_op,
    output rv_exec_pkg::reg_addr_t ex_rd,
    output logic                   ex_wr
);
    import rv_exec_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;      // instr[30], selects SUB and SRA
    reg_addr_t  rd_f;
    reg_addr_t  rs1_f;
    reg_addr_t  rs2_f;
    word_t      imm_i;
    word_t      imm_u;

    word_t      a_next;
    word_t      b_next;
    alu_op_t    op_next;
    logic       legal;    // Opcode belongs to a kept group

    // funct3 to ALU code, sub and sra come from bit 30 where it applies
    function automatic alu_op_t f3_to_op(logic [2:0] f3, logic sub, logic sra);
        alu_op_t op;
        case (f3)
            `F3_ADD_SUB: op = sub ? `ALU_SUB : `ALU_ADD;
            `F3_SLL:     op = `ALU_SLL;
            `F3_SLT:     op = `ALU_SLT;
            `F3_SLTU:    op = `ALU_SLTU;
            `F3_XOR:     op = `ALU_XOR;
            `F3_SRL_SRA: op = sra ? `ALU_SRA : `ALU_SRL;
            `F3_OR:      op = `ALU_OR;
            `F3_AND:     op = `ALU_AND;
            default:     op = `ALU_ADD;
        endcase
        return op;
    endfunction

    // Instruction fields
    assign opcode = instr[6:0];
    assign rd_f   = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];
    assign alt    = instr[30];
    assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};  // Sign-extended I-type
    assign imm_u  = {instr[31:12], 12'd0};                    // LUI value, low bits clear

    always_comb begin
        rs1_addr = '0;  // Unused ports read x0
        rs2_addr = '0;
        a_next   = '0;
        b_next   = '0;
        op_next  = `ALU_ADD;
        legal    = 1'b0;

        case (opcode)
            `OPC_LUI: begin
                a_next = imm_u;     // Upper immediate plus zero
                legal  = 1'b1;
            end
            `OPC_OP_IMM: begin
                rs1_addr = rs1_f;
                a_next   = rs1_value;
                b_next   = imm_i;   // Shifts only look at the low 5 bits
                op_next  = f3_to_op(funct3, 1'b0, alt);  // No SUBI, bit 30 is immediate there
                legal    = 1'b1;
            end
            `OPC_OP: begin
                rs1_addr = rs1_f;
                rs2_addr = rs2_f;
                a_next   = rs1_value;
                b_next   = rs2_value;
                op_next  = f3_to_op(funct3, alt, alt);
                legal    = 1'b1;
            end
            `OPC_BUBBLE: begin
                legal = 1'b0;       // Explicit no-op
            end
            default: begin
                legal = 1'b0;       // Unsupported opcode, dropped as a bubble
            end
        endcase
    end

    // Execute-stage payload
    always_ff @(posedge clk) begin
        ex_a  <= a_next;
        ex_b  <= b_next;
        ex_op <= op_next;
        ex_rd <= rd_f;
    end

    // Write flag, never set for x0 so later stages skip that check
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_wr <= 1'b0;
        end else begin
            ex_wr <= instr_valid && legal && (rd_f != '0);
        end
    end

endmodule

// ==== hw/rv_exec_core.sv ====
`timescale 1ns/1ps

module rv_exec_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,  // One-cycle issue strobe
    input  rv_exec_pkg::instr_t   instr,
    output logic                  wb_valid,
    output rv_exec_pkg::reg_addr_t wb_rd,
    output rv_exec_pkg::word_t    wb_data
);
    import rv_exec_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;   // Straight from the register file
    word_t     rs2_data;
    word_t     rs1_value;  // After forwarding
    word_t     rs2_value;
    word_t     ex_a;
    word_t     ex_b;
    alu_op_t   ex_op;
    reg_addr_t ex_rd;
    logic      ex_wr;
    word_t     ex_result;

    // Decode and operand select, registers the execute stage
    rv_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_wr       (ex_wr)
    );

    // Architectural registers, written from the write-back stage
    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .a      (ex_a),
        .b      (ex_b),
        .op     (ex_op),
        .result (ex_result)
    );

    // Memory and write-back stages plus bypass muxes
    inflight_forward u_inflight_forward (
        .clk       (clk),
        .rst       (rst),
        .ex_rd     (ex_rd),
        .ex_wr     (ex_wr),
        .ex_result (ex_result),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

// ==== verification/tb_rv_exec_core.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module tb_rv_exec_core;
    import rv_exec_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int TEST_LEN = 250;                  // Instructions per test
    localparam logic [31:0] SEED = 32'hf6a4_407e;
    // Worst case of four cycles per instruction plus drain per test, reset and margin
    localparam int MAX_CYCLES = NUM_TESTS * (TEST_LEN * 4 + 8) + 2 + 50;

    typedef struct packed {
        logic [2:0] test;   // Test that issued it
        reg_addr_t  rd;
        word_t      data;
    } wb_rec_t;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    logic        exp_wr;                // Strobed instruction should write back
    logic [2:0]  exp_pipe = '0;         // exp_wr delayed to the write-back cycle
    logic [31:0] lfsr;
    word_t       ref_regs [0:31];       // In-order architectural model
    wb_rec_t     exp_q [$];
    wb_rec_t     head;
    string       test_name [0:NUM_TESTS-1] = '{"op_imm", "op_reg", "lui_fwd", "bubble", "mixed"};
    int          test_errors [0:NUM_TESTS-1];
    int          cur_test = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    rv_exec_core u_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};          // One step per bit
        end
    endtask

    // Only the three kept groups write, and never x0
    function automatic logic writes_reg(instr_t ins);
        logic known;
        known = (ins[6:0] == `OPC_LUI) || (ins[6:0] == `OPC_OP_IMM) || (ins[6:0] == `OPC_OP);
        return known && (ins[11:7] != 5'd0);
    endfunction

    function automatic word_t ref_result(instr_t ins, word_t x1, word_t x2);
        word_t      b;
        word_t      r;
        logic [4:0] sh;
        b  = (ins[6:0] == `OPC_OP) ? x2 : {{20{ins[31]}}, ins[31:20]};  // I-imm sign-extended
        sh = b[4:0];
        case (ins[14:12])
            3'b000:  r = (ins[6:0] == `OPC_OP && ins[30]) ? x1 - b : x1 + b;
            3'b001:  r = x1 << sh;
            3'b010:  r = (x1[31] != b[31]) ? {31'd0, x1[31]} : {31'd0, x1 < b};  // Signs differ
            3'b011:  r = {31'd0, x1 < b};
            3'b100:  r = x1 ^ b;
            3'b101:  r = (ins[30] && x1[31]) ? (x1 >> sh) | ~(32'hffff_ffff >> sh) : x1 >> sh;
            3'b110:  r = x1 | b;
            default: r = x1 & b;
        endcase
        if (ins[6:0] == `OPC_LUI) r = {ins[31:12], 12'h000};
        return r;
    endfunction

    // Random instruction with registers kept in x0..x7 so hazards are frequent
    task automatic make_instr(input int t, output instr_t ins);
        logic [31:0] r;
        int          kind;
        draw_bits(2, r);
        case (t)
            0:       kind = 0;
            1:       kind = 1;
            2:       kind = (r[1:0] == 2'd0) ? 2 : int'(r[0]);
            3:       kind = r[1] ? 3 : int'(r[0]);
            default: kind = int'(r[1:0]);
        endcase
        draw_bits(32, r);
        ins = r;
        ins[11:10] = 2'b00;                  // rd
        ins[19:18] = 2'b00;                  // rs1
        case (kind)
            0: begin
                ins[6:0] = `OPC_OP_IMM;
                if (ins[14:12] == 3'b001) ins[31:25] = 7'd0;
                if (ins[14:12] == 3'b101) ins[31:25] = {1'b0, ins[30], 5'd0};  // SRLI or SRAI
            end
            1: begin
                ins[6:0]   = `OPC_OP;
                ins[24:23] = 2'b00;          // rs2
                ins[31:25] = {1'b0, ins[30], 5'd0};
            end
            2: ins[6:0] = `OPC_LUI;
            default: begin
                draw_bits(2, r);
                case (r[1:0])
                    2'd0: ins = '0;          // Opcode zero
                    2'd1: ins[6:0] = 7'b110_0011;   // Branch opcode is dropped
                    2'd2: ins[6:0] = 7'b000_0011;   // Load opcode is dropped
                    default: begin
                        ins[6:0]  = `OPC_OP_IMM;
                        ins[11:7] = 5'd0;    // Legal but aimed at x0
                    end
                endcase
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Write-back checks three edges after the strobe
    always @(posedge clk) begin
        if (!rst) begin
            valid_chk: assert (wb_valid == exp_pipe[2]) else begin
                $display("Fail %s wb_valid expected %0b actual %0b",
                         test_name[cur_test], exp_pipe[2], wb_valid);
                errors++;
                test_errors[cur_test]++;
            end
            if (wb_valid && exp_q.size() != 0) begin
                head = exp_q.pop_front();
                checks++;
                rd_chk: assert (wb_rd == head.rd) else begin
                    $display("Fail %s wb_rd expected %0d actual %0d",
                             test_name[head.test], head.rd, wb_rd);
                    errors++;
                    test_errors[head.test]++;
                end
                data_chk: assert (wb_data == head.data) else begin
                    $display("Fail %s wb_data expected %h actual %h",
                             test_name[head.test], head.data, wb_data);
                    errors++;
                    test_errors[head.test]++;
                end
            end
        end
        exp_pipe <= {exp_pipe[1:0], exp_wr};
    end

    initial begin
        logic [31:0] r;
        instr_t      ins;
        logic        wr;
        word_t       res;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        exp_wr = 1'b0;
        lfsr = SEED;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;      // Matches the cleared register file
        for (int i = 0; i < NUM_TESTS; i++) test_errors[i] = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = t;
            for (int n = 0; n < TEST_LEN; n++) begin
                make_instr(t, ins);
                wr  = writes_reg(ins);
                res = ref_result(ins, ref_regs[ins[19:15]], ref_regs[ins[24:20]]);
                if (wr) begin
                    ref_regs[ins[11:7]] = res;
                    exp_q.push_back('{t[2:0], ins[11:7], res});
                end
                instr_valid = 1'b1;
                instr = ins;
                exp_wr = wr;
                @(negedge clk);
                instr_valid = 1'b0;
                instr = '0;
                exp_wr = 1'b0;
                draw_bits(2, r);
                repeat (r[1:0]) @(negedge clk);   // Gap of 0 to 3 cycles
            end
            repeat (4) @(negedge clk);            // Fixed latency lets the last write-back out
            drain_chk: assert (exp_q.size() == 0) else begin
                $display("%0d expected write-backs of test %s never appeared",
                         exp_q.size(), test_name[t]);
                errors++;
                test_errors[t]++;
                exp_q.delete();
            end
            $display("Test %s finished: %0d instructions, %0d errors",
                     test_name[t], TEST_LEN, test_errors[t]);
        end
        $display("Summary: %0d tests, %0d write-backs checked, %0d errors",
                 NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hw/rv_exec_pkg.sv
hw/rv_alu.sv
hw/reg_file.sv
hw/inflight_forward.sv
hw/rv_decoder.sv
hw/rv_exec_core.sv
verification/tb_rv_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_exec_core \
    -f verilog.f \
    -o sim_tb_rv_exec_core

./obj_dir/sim_tb_rv_exec_core | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
